//--- tb.f
+incdir+test
design/bp_pkg.sv
design/fetch_pc_stage.sv
design/predecode_stage.sv
design/gshare_pht.sv
design/return_stack.sv
design/branch_pred.sv
test/tb_branch_pred.sv

//--- run_sim.sh
#!/bin/sh
# build and run the branch predictor testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f tb.f --top-module tb_branch_pred -o tb_sim > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
  cat build.log
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "sim failed" sim.log; then
  exit 1
fi
exit 0

//--- test/tb_cases.svh
// program image: branches placed at fixed word addresses, everything else is nop

task automatic load_program();
  put_word(64'h108, 32'h14000010);  // b to 0x148
  put_word(64'h148, 32'h9400002E);  // bl to 0x200
  put_word(64'h204, 32'h9400003F);  // bl to 0x300, second level
  put_word(64'h300, 32'hD65F03C0);  // ret
  put_word(64'h20C, 32'hD65F03C0);  // ret back to 0x14c
  put_word(64'h404, 32'h540001E1);  // b.ne to 0x440
endtask

// columns: redirect, wait for busy, redirect pc, word offset,
// expected start, count, slot kinds 0..3, expected pred_pc
task automatic load_cases();
  // straight line from reset
  add_row(0, 0, 64'h0, 0, 64'h000, 4, NONE, NONE, NONE, NONE, 64'h010);
  add_row(0, 0, 64'h0, 0, 64'h010, 4, NONE, NONE, NONE, NONE, 64'h020);
  // line offset 56 leaves two slots
  add_row(1, 0, 64'h48, -4, 64'h038, 2, NONE, NONE, NONE, NONE, 64'h040);
  add_row(0, 0, 64'h0, 0, 64'h040, 4, NONE, NONE, NONE, NONE, 64'h050);
  // b, then bl two deep and both returns
  add_row(1, 0, 64'h100, 0, 64'h100, 3, NONE, NONE, B, NONE, 64'h148);
  add_row(0, 0, 64'h0, 0, 64'h148, 1, BL, NONE, NONE, NONE, 64'h200);
  add_row(0, 0, 64'h0, 0, 64'h200, 2, NONE, BL, NONE, NONE, 64'h300);
  add_row(0, 0, 64'h0, 0, 64'h300, 1, RET, NONE, NONE, NONE, 64'h208);
  add_row(0, 0, 64'h0, 0, 64'h208, 2, NONE, RET, NONE, NONE, 64'h14C);
  add_row(0, 0, 64'h0, 0, 64'h14C, 4, NONE, NONE, NONE, NONE, 64'h15C);
  // b.cond cold, not taken
  add_row(1, 0, 64'h400, 0, 64'h400, 4, NONE, BCOND, NONE, NONE, 64'h410);
  // fill history with ones, then train the b.cond twice at that history
  add_row(1, 0, 64'h400, 0, 64'h400, 2, NONE, BCOND, NONE, NONE, 64'h440);
  add_res(64'h900, 1);
  add_res(64'h900, 1);
  add_res(64'h900, 1);
  add_res(64'h900, 1);
  add_res(64'h404, 1);
  add_res(64'h404, 1);
  add_row(0, 0, 64'h0, 0, 64'h440, 4, NONE, NONE, NONE, NONE, 64'h450);
  // correction while a line is still in flight
  add_row(1, 1, 64'h4F0, 4, 64'h500, 4, NONE, NONE, NONE, NONE, 64'h510);
endtask

//--- test/tb_branch_pred.sv
`timescale 1ns/1ps

module tb_branch_pred;
  import bp_pkg::*;

  localparam int MAX_CASES  = 16;
  localparam int MAX_RES    = 6;
  localparam int WAIT_LIMIT = 60;   // cycles per wait loop

  // one row of the stimulus table
  typedef struct packed {
    logic                             redir;      // restart fetch before the row
    logic                             busy;       // redirect only with a line in flight
    logic [ADDR_W-1:0]                redir_pc;
    logic signed [18:0]               redir_off;
    logic [2:0]                       n_res;
    logic [MAX_RES-1:0][ADDR_W-1:0]   res_pc;
    logic [MAX_RES-1:0]               res_taken;
    logic [ADDR_W-1:0]                exp_start;
    logic [CNT_W-1:0]                 exp_count;
    br_kind_e [SS_WIDTH-1:0]          exp_kind;
    logic [ADDR_W-1:0]                exp_pred;
  } case_t;

  logic              clk_in;
  logic              rst_N_in;
  logic              l1i_req_valid;
  logic [ADDR_W-1:0] l1i_req_addr;
  logic              l1i_req_ready;
  logic              l1i_valid;
  line_t             l1i_line;
  logic              x_resolve_valid;
  resolve_t          x_resolve;
  logic              x_redirect_valid;
  redirect_t         x_redirect;
  logic              window_valid;
  window_t           window;
  logic [ADDR_W-1:0] pred_pc;

  case_t             cases [MAX_CASES];
  int                n_cases;
  bit [31:0]         imem [longint unsigned];   // sparse, keyed by word address
  logic [ADDR_W-1:0] q_addr [$];                // cache requests in flight
  int                q_due [$];
  int                last_due;
  int                cyc;
  bit [31:0]         seed;
  bit [PHT_K-1:0]    ghr;                       // reference history, newest in bit 0
  bit [1:0]          cnt [PHT_SIZE];
  logic              nx_redir_v;                // staged for the next falling edge
  redirect_t         nx_redir;
  logic              nx_res_v;
  resolve_t          nx_res;
  logic              win_v_s;                   // outputs sampled after the falling edge
  window_t           win_s;
  logic [ADDR_W-1:0] pred_s;
  logic              req_v_s;
  logic [ADDR_W-1:0] req_a_s;
  int                errors;
  int                checks;
  int                row_errors;
  int                cur_row;
  bit                aborted;

  branch_pred dut0 (
    .clk_in(clk_in), .rst_N_in(rst_N_in),
    .l1i_req_valid(l1i_req_valid), .l1i_req_addr(l1i_req_addr),
    .l1i_req_ready(l1i_req_ready), .l1i_valid(l1i_valid), .l1i_line(l1i_line),
    .x_resolve_valid(x_resolve_valid), .x_resolve(x_resolve),
    .x_redirect_valid(x_redirect_valid), .x_redirect(x_redirect),
    .window_valid(window_valid), .window(window), .pred_pc(pred_pc)
  );

  initial begin
    clk_in = 1'b0;
    forever #10 clk_in = ~clk_in;
  end

  function automatic bit [31:0] lcg_next();
    seed = seed * 32'd1103515245 + 32'd12345;
    return seed;
  endfunction

  function automatic bit [31:0] fetch_word(input logic [ADDR_W-1:0] addr);
    longint unsigned key;
    key = longint'(addr >> 2);
    return imem.exists(key) ? imem[key] : 32'h0;  // unwritten memory reads as nop
  endfunction

  function automatic line_t build_line(input logic [ADDR_W-1:0] addr);
    line_t             ln;
    logic [ADDR_W-1:0] base;
    base = addr & ~ADDR_W'(LINE_BYTES - 1);
    for (int w = 0; w < LINE_BYTES / 4; w++) begin
      ln[4*w +: 4] = fetch_word(base + ADDR_W'(4 * w));  // low byte first
    end
    return ln;
  endfunction

  task automatic put_word(input logic [ADDR_W-1:0] addr, input bit [31:0] word);
    imem[longint'(addr >> 2)] = word;
  endtask

  task automatic add_row(input bit redir, input bit busy, input logic [ADDR_W-1:0] rpc,
                         input int roff, input logic [ADDR_W-1:0] start, input int count,
                         input br_kind_e k0, input br_kind_e k1, input br_kind_e k2,
                         input br_kind_e k3, input logic [ADDR_W-1:0] pred);
    cases[n_cases]             = '0;
    cases[n_cases].redir       = redir;
    cases[n_cases].busy        = busy;
    cases[n_cases].redir_pc    = rpc;
    cases[n_cases].redir_off   = 19'(roff);
    cases[n_cases].exp_start   = start;
    cases[n_cases].exp_count   = CNT_W'(count);
    cases[n_cases].exp_kind[0] = k0;
    cases[n_cases].exp_kind[1] = k1;
    cases[n_cases].exp_kind[2] = k2;
    cases[n_cases].exp_kind[3] = k3;
    cases[n_cases].exp_pred    = pred;
    n_cases++;
  endtask

  // resolution driven ahead of the last added row
  task automatic add_res(input logic [ADDR_W-1:0] pc, input bit taken);
    int r;
    int k;
    r = n_cases - 1;
    k = int'(cases[r].n_res);
    cases[r].res_pc[k]    = pc;
    cases[r].res_taken[k] = taken;
    cases[r].n_res        = cases[r].n_res + 3'd1;
  endtask

  `include "tb_cases.svh"

  // reference gshare entry is history * 64 plus word address bits
  function automatic bit predict_model(input logic [ADDR_W-1:0] pc);
    int idx;
    idx = int'(ghr) * (1 << PHT_N) + int'(pc[PHT_N+1:2]);
    return cnt[idx] >= 2'd2;
  endfunction

  task automatic train_model(input logic [ADDR_W-1:0] pc, input bit taken);
    int idx;
    idx = int'(ghr) * (1 << PHT_N) + int'(pc[PHT_N+1:2]);
    if (taken && cnt[idx] < 2'd3) cnt[idx] = cnt[idx] + 2'd1;
    else if (!taken && cnt[idx] > 2'd0) cnt[idx] = cnt[idx] - 2'd1;
    ghr = {ghr[PHT_K-2:0], taken};
  endtask

  // one cycle of cache response and staged pulses on the falling edge, then sample
  task automatic tick();
    int due;
    @(negedge clk_in);
    cyc++;
    l1i_valid = 1'b0;
    if (q_addr.size() > 0 && q_due[0] <= cyc) begin
      l1i_valid = 1'b1;
      l1i_line  = build_line(q_addr[0]);
      void'(q_addr.pop_front());
      void'(q_due.pop_front());
    end
    x_redirect_valid = nx_redir_v;
    x_redirect       = nx_redir;
    nx_redir_v       = 1'b0;
    x_resolve_valid  = nx_res_v;
    x_resolve        = nx_res;
    nx_res_v         = 1'b0;
    #1;
    win_v_s = window_valid;
    win_s   = window;
    pred_s  = pred_pc;
    req_v_s = l1i_req_valid;
    req_a_s = l1i_req_addr;
    if (l1i_req_valid && l1i_req_ready) begin  // fires on the coming rising edge
      due = cyc + 1 + int'((lcg_next() >> 16) % 4);
      if (due <= last_due) due = last_due + 1;  // responses stay in order
      last_due = due;
      q_addr.push_back(l1i_req_addr);
      q_due.push_back(due);
    end
  endtask

  task automatic check_value(input string what, input logic [ADDR_W-1:0] got,
                             input logic [ADDR_W-1:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("error: t=%0t row %0d %s got %h expected %h", $time, cur_row, what, got, exp);
      errors++;
      row_errors++;
    end
  endtask

  task automatic run_row(input int r);
    case_t             c;
    int                n;
    logic [ADDR_W-1:0] tgt;
    logic [ADDR_W-1:0] spc;
    c          = cases[r];
    cur_row    = r;
    row_errors = 0;
    for (int k = 0; k < int'(c.n_res); k++) begin
      nx_res_v = 1'b1;
      nx_res   = '{pc: c.res_pc[k], taken: c.res_taken[k]};
      tick();
      train_model(c.res_pc[k], c.res_taken[k]);
    end
    n = 0;
    while (c.busy && !(q_addr.size() > 0 && q_due[0] > cyc + 1) && n < WAIT_LIMIT) begin
      tick();
      n++;
    end
    if (c.busy && n >= WAIT_LIMIT) begin
      $display("timeout: row %0d never saw a cache request in flight", r);
      aborted = 1'b1;
      return;
    end
    if (c.redir) begin
      tgt        = c.redir_pc + ADDR_W'(longint'($signed(c.redir_off)) * 4);
      nx_redir_v = 1'b1;
      nx_redir   = '{pc: c.redir_pc, offset: c.redir_off};
      tick();                                  // window seen here is off path
      tick();
      // a line that met the redirect is dropped
      check_value("window after redirect", ADDR_W'(win_v_s), ADDR_W'(0));
      check_value("redirect request valid", ADDR_W'(req_v_s), ADDR_W'(1));
      check_value("redirect request addr", req_a_s, tgt);
    end
    n = 0;
    do begin
      tick();
      n++;
    end while (!win_v_s && n < WAIT_LIMIT);
    if (!win_v_s) begin
      $display("timeout: row %0d waited %0d cycles and got no fetch window", r, n);
      aborted = 1'b1;
      return;
    end
    check_value("window start", win_s.start_pc, c.exp_start);
    check_value("slot count", ADDR_W'(win_s.count), ADDR_W'(c.exp_count));
    check_value("pred_pc", pred_s, c.exp_pred);
    for (int i = 0; i < int'(c.exp_count); i++) begin
      spc = c.exp_start + ADDR_W'(4 * i);
      check_value($sformatf("slot %0d kind", i), ADDR_W'(win_s.slots[i].kind),
                  ADDR_W'(c.exp_kind[i]));
      check_value($sformatf("slot %0d predict", i), ADDR_W'(win_s.slots[i].predict_taken),
                  ADDR_W'((c.exp_kind[i] == BCOND) ? predict_model(spc) : 1'b0));
      // an ending branch that is followed points at the next fetch address
      if (i == int'(c.exp_count) - 1 &&
          (c.exp_kind[i] inside {B, BL, RET} ||
           (c.exp_kind[i] == BCOND && predict_model(spc)))) begin
        check_value($sformatf("slot %0d target", i), win_s.slots[i].target, c.exp_pred);
      end
    end
    $display("row %0d done, %0d errors", r, row_errors);
  endtask

  initial begin
    rst_N_in         = 1'b1;   // reset asserted
    l1i_req_ready    = 1'b1;   // cache always takes requests
    l1i_valid        = 1'b0;
    l1i_line         = '0;
    x_resolve_valid  = 1'b0;
    x_resolve        = '0;
    x_redirect_valid = 1'b0;
    x_redirect       = '0;
    nx_redir_v       = 1'b0;
    nx_redir         = '0;
    nx_res_v         = 1'b0;
    nx_res           = '0;
    seed             = 32'd19638;
    ghr              = '0;
    cyc              = 0;
    last_due         = 0;
    errors           = 0;
    checks           = 0;
    aborted          = 1'b0;
    n_cases          = 0;
    for (int i = 0; i < PHT_SIZE; i++) cnt[i] = 2'd1;
    load_program();
    load_cases();
    repeat (4) @(posedge clk_in);
    @(negedge clk_in);
    rst_N_in = 1'b0;
    for (int r = 0; r < n_cases; r++) begin
      if (aborted) break;
      run_row(r);
    end
    $display("rows %0d, checks %0d, errors %0d", n_cases, checks, errors);
    if (errors == 0 && !aborted) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

//--- design/branch_pred.sv
`timescale 1ns/1ps

module branch_pred (
  input  logic                        clk_in,
  input  logic                        rst_N_in,
  output logic                        l1i_req_valid,
  output logic [bp_pkg::ADDR_W-1:0]   l1i_req_addr,
  input  logic                        l1i_req_ready,
  input  logic                        l1i_valid,
  input  bp_pkg::line_t               l1i_line,
  input  logic                        x_resolve_valid,
  input  bp_pkg::resolve_t            x_resolve,
  input  logic                        x_redirect_valid,
  input  bp_pkg::redirect_t           x_redirect,
  output logic                        window_valid,
  output bp_pkg::window_t             window,
  output logic [bp_pkg::ADDR_W-1:0]   pred_pc
);
  import bp_pkg::*;

  logic                            line_valid;
  line_t                           line;
  logic [ADDR_W-1:0]               line_pc;
  logic                            dec_valid;
  decode_t                         dec;
  logic [SS_WIDTH-1:0][ADDR_W-1:0] slot_pc;
  logic [SS_WIDTH-1:0]             slot_taken;   // pht says taken, per slot
  logic [ADDR_W-1:0]               ras_top;
  logic                            ras_push;
  logic                            ras_pop;
  logic                            taken_hit;    // some b.cond predicted taken
  logic [SLOT_IDX_W-1:0]           taken_idx;

  fetch_pc_stage u_fetch (
    .clk_in(clk_in), .rst_N_in(rst_N_in),
    .next_valid(dec_valid), .next_pc(pred_pc),
    .redirect_valid(x_redirect_valid), .redirect(x_redirect),
    .l1i_req_ready(l1i_req_ready), .l1i_valid(l1i_valid), .l1i_line(l1i_line),
    .l1i_req_valid(l1i_req_valid), .l1i_req_addr(l1i_req_addr),
    .line_valid(line_valid), .line(line), .line_pc(line_pc)
  );

  predecode_stage u_predecode (
    .clk_in(clk_in), .rst_N_in(rst_N_in),
    .line_valid(line_valid), .line(line), .line_pc(line_pc),
    .flush(x_redirect_valid),
    .dec_valid(dec_valid), .dec(dec)
  );

  gshare_pht u_pht (
    .clk_in(clk_in), .rst_N_in(rst_N_in),
    .lookup_pc(slot_pc), .lookup_taken(slot_taken),
    .train_valid(x_resolve_valid), .train(x_resolve)
  );

  return_stack u_ras (
    .clk_in(clk_in), .rst_N_in(rst_N_in),
    .push(ras_push), .push_addr(dec.end_pc + ADDR_W'(4)),
    .pop(ras_pop), .top(ras_top)
  );

  always_comb begin
    for (int i = 0; i < SS_WIDTH; i++) begin
      slot_pc[i] = dec.win.start_pc + ADDR_W'(4 * i);
    end
  end

  // attach predictions, cut the window after the first taken b.cond
  always_comb begin
    window    = dec.win;
    taken_hit = 1'b0;
    taken_idx = '0;
    for (int i = 0; i < SS_WIDTH; i++) begin
      if (taken_hit) begin
        window.slots[i] = '0;  // falls behind a taken branch
      end else if (dec.win.slots[i].kind == BCOND) begin
        window.slots[i].predict_taken = slot_taken[i];
        if (slot_taken[i]) begin
          taken_hit    = 1'b1;
          taken_idx    = SLOT_IDX_W'(i);
          window.count = CNT_W'(i + 1);
        end
      end else if (dec.win.slots[i].kind == RET) begin
        window.slots[i].target = ras_top;  // ret target is the predicted return
      end
    end
  end

  always_comb begin
    if (taken_hit) begin
      pred_pc = dec.win.slots[taken_idx].target;
    end else begin
      case (dec.end_kind)
        B, BL:   pred_pc = dec.end_target;
        RET:     pred_pc = ras_top;
        default: pred_pc = dec.end_pc + ADDR_W'(4);  // fall through past the last slot
      endcase
    end
  end

  // a taken b.cond earlier in the window drops the bl / ret
  assign ras_push     = dec_valid && !taken_hit && (dec.end_kind == BL);
  assign ras_pop      = dec_valid && !taken_hit && (dec.end_kind == RET);
  assign window_valid = dec_valid;

  // every window fetches its successor in the same cycle
  a_window_req: assert property (@(posedge clk_in) disable iff (rst_N_in)
    window_valid && !x_redirect_valid |-> l1i_req_valid && l1i_req_addr == pred_pc)
    else $error("window published without a request for pred_pc");

endmodule

//--- design/return_stack.sv
`timescale 1ns/1ps

module return_stack (
  input  logic                        clk_in,
  input  logic                        rst_N_in,
  input  logic                        push,
  input  logic [bp_pkg::ADDR_W-1:0]   push_addr,
  input  logic                        pop,
  output logic [bp_pkg::ADDR_W-1:0]   top
);
  import bp_pkg::*;

  logic [ADDR_W-1:0]    mem_q [RAS_DEPTH];
  logic [RAS_PTR_W-1:0] tos_q;     // slot of the current top
  logic [RAS_CNT_W-1:0] cnt_q;     // live entries, saturates at depth
  logic [RAS_PTR_W-1:0] tos_up;

  assign tos_up = tos_q + 1'b1;    // wraps, oldest entry overwritten
  assign top    = (cnt_q == '0) ? '0 : mem_q[tos_q];

  always_ff @(posedge clk_in) begin
    if (rst_N_in) begin
      tos_q <= '0;
      cnt_q <= '0;
    end else if (push) begin
      tos_q <= tos_up;
      if (cnt_q != RAS_CNT_W'(RAS_DEPTH)) begin
        cnt_q <= cnt_q + 1'b1;
      end
    end else if (pop && cnt_q != '0) begin  // pop on empty is ignored
      tos_q <= tos_q - 1'b1;
      cnt_q <= cnt_q - 1'b1;
    end
  end

  always_ff @(posedge clk_in) begin
    if (push) begin
      mem_q[tos_up] <= push_addr;
    end
  end

  // bl and ret never share a window, so both at once means a broken window
  a_push_pop: assert property (@(posedge clk_in) disable iff (rst_N_in) !(push && pop))
    else $error("return stack push and pop in the same cycle");

endmodule

//--- design/gshare_pht.sv
`timescale 1ns/1ps

module gshare_pht (
  input  logic                                           clk_in,
  input  logic                                           rst_N_in,
  input  logic [bp_pkg::SS_WIDTH-1:0][bp_pkg::ADDR_W-1:0] lookup_pc,     // one per slot
  output logic [bp_pkg::SS_WIDTH-1:0]                    lookup_taken,
  input  logic                                           train_valid,
  input  bp_pkg::resolve_t                               train
);
  import bp_pkg::*;

  logic [PHT_K-1:0]     ghr_q;              // newest outcome in bit 0
  logic [1:0]           pht_q [PHT_SIZE];   // 2-bit saturating counters
  logic [PHT_IDX_W-1:0] train_idx;
  logic [1:0]           train_ctr;

  // history on top, word address bits below
  function automatic logic [PHT_IDX_W-1:0] pht_index(input logic [PHT_K-1:0] hist,
                                                     input logic [ADDR_W-1:0] pc);
    return {hist, pc[PHT_N+1:2]};
  endfunction

  // all slots read against the same history
  always_comb begin
    for (int i = 0; i < SS_WIDTH; i++) begin
      lookup_taken[i] = pht_q[pht_index(ghr_q, lookup_pc[i])][1];  // counter >= 2
    end
  end

  assign train_idx = pht_index(ghr_q, train.pc);
  assign train_ctr = pht_q[train_idx];

  always_ff @(posedge clk_in) begin
    if (rst_N_in) begin
      ghr_q <= '0;
      for (int i = 0; i < PHT_SIZE; i++) begin
        pht_q[i] <= 2'd1;  // weakly not taken
      end
    end else if (train_valid) begin
      ghr_q <= {ghr_q[PHT_K-2:0], train.taken};
      if (train.taken && train_ctr != 2'd3) begin
        pht_q[train_idx] <= train_ctr + 2'd1;
      end else if (!train.taken && train_ctr != 2'd0) begin
        pht_q[train_idx] <= train_ctr - 2'd1;
      end
    end
  end

endmodule

//--- design/predecode_stage.sv
`timescale 1ns/1ps

module predecode_stage (
  input  logic                        clk_in,
  input  logic                        rst_N_in,
  input  logic                        line_valid,
  input  bp_pkg::line_t               line,
  input  logic [bp_pkg::ADDR_W-1:0]   line_pc,
  input  logic                        flush,
  output logic                        dec_valid,
  output bp_pkg::decode_t             dec
);
  import bp_pkg::*;

  logic [LINE_OFF_W-1:0] base_off;    // byte offset of the first slot
  logic [LINE_OFF_W:0]   bytes_left;  // 4..64
  logic [LINE_OFF_W:0]   words_left;
  logic [CNT_W-1:0]      avail;       // slots before the line ends, capped
  decode_t               dec_d;

  assign base_off   = line_pc[LINE_OFF_W-1:0];
  assign bytes_left = (LINE_OFF_W+1)'(LINE_BYTES) - {1'b0, base_off};
  assign words_left = bytes_left >> 2;
  assign avail      = (words_left >= (LINE_OFF_W+1)'(SS_WIDTH)) ? CNT_W'(SS_WIDTH)
                                                                : CNT_W'(words_left);

  // walk the slots in order, stop after the first unconditional branch
  always_comb begin
    logic                  done;
    logic [LINE_OFF_W-1:0] off;
    logic [31:0]           instr;
    logic [ADDR_W-1:0]     pc;
    logic [ADDR_W-1:0]     tgt;
    br_kind_e              kind;
    dec_d              = '0;
    dec_d.win.start_pc = line_pc;
    done               = 1'b0;
    for (int i = 0; i < SS_WIDTH; i++) begin
      off   = base_off + LINE_OFF_W'(4 * i);  // wraps only for slots past avail
      instr = line[off +: 4];                 // little endian word
      pc    = line_pc + ADDR_W'(4 * i);
      kind  = classify(instr);
      case (kind)
        B, BL:   tgt = pc + imm26_off(instr);
        BCOND:   tgt = pc + imm19_off(instr);
        default: tgt = '0;                    // ret target comes from the stack
      endcase
      if (!done && CNT_W'(i) < avail) begin
        dec_d.win.count           = CNT_W'(i + 1);
        dec_d.win.slots[i].kind   = kind;
        dec_d.win.slots[i].cond   = (kind == BCOND) ? instr[3:0] : 4'd0;
        dec_d.win.slots[i].target = tgt;
        // last recorded slot ends the window
        dec_d.end_idx    = SLOT_IDX_W'(i);
        dec_d.end_kind   = kind;
        dec_d.end_pc     = pc;
        dec_d.end_target = tgt;
        // b.cond does not end the scan here, the predictor may cut it later
        done = (kind == B) || (kind == BL) || (kind == RET);
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (rst_N_in) begin
      dec_valid <= 1'b0;
    end else begin
      dec_valid <= line_valid && !flush;  // a correction kills the line in flight
    end
  end

  always_ff @(posedge clk_in) begin
    if (line_valid) begin
      dec <= dec_d;
    end
  end

endmodule

//--- design/fetch_pc_stage.sv
`timescale 1ns/1ps

module fetch_pc_stage (
  input  logic                        clk_in,
  input  logic                        rst_N_in,
  input  logic                        next_valid,
  input  logic [bp_pkg::ADDR_W-1:0]   next_pc,
  input  logic                        redirect_valid,
  input  bp_pkg::redirect_t           redirect,
  input  logic                        l1i_req_ready,
  input  logic                        l1i_valid,
  input  bp_pkg::line_t               l1i_line,
  output logic                        l1i_req_valid,
  output logic [bp_pkg::ADDR_W-1:0]   l1i_req_addr,
  output logic                        line_valid,
  output bp_pkg::line_t               line,
  output logic [bp_pkg::ADDR_W-1:0]   line_pc
);
  import bp_pkg::*;

  logic              boot_q;         // first cycle out of reset
  logic              pend_q;         // request waiting for ready
  logic [ADDR_W-1:0] pend_addr_q;
  logic [ADDR_W-1:0] await_pc_q;     // address of the request in flight
  logic              outstanding_q;  // live request in flight
  logic              squash_q;       // stale request in flight, drop its line
  logic              req_fire;
  logic              resp_live;
  logic              live_after;
  logic [ADDR_W-1:0] redirect_pc;

  assign redirect_pc = redirect.pc + {{(ADDR_W-21){redirect.offset[18]}}, redirect.offset, 2'b00};

  // a window's next address goes out the same cycle, unless a redirect overrides it
  assign l1i_req_valid = pend_q || (next_valid && !redirect_valid);
  assign l1i_req_addr  = pend_q ? pend_addr_q : next_pc;
  assign req_fire      = l1i_req_valid && l1i_req_ready;

  assign resp_live  = l1i_valid && outstanding_q && !squash_q;
  assign live_after = (outstanding_q && !resp_live) || req_fire;  // still in flight after this edge

  assign line_valid = resp_live;
  assign line       = l1i_line;
  assign line_pc    = await_pc_q;

  always_ff @(posedge clk_in) begin
    if (rst_N_in) begin
      boot_q        <= 1'b1;
      pend_q        <= 1'b0;
      outstanding_q <= 1'b0;
      squash_q      <= 1'b0;
    end else begin
      boot_q <= 1'b0;
      if (l1i_valid && squash_q) squash_q <= 1'b0;  // stale line swallowed
      if (resp_live) outstanding_q <= 1'b0;
      if (req_fire) outstanding_q <= 1'b1;
      if (redirect_valid) begin
        pend_q <= 1'b1;
        if (live_after) begin  // whatever is in flight is now on the wrong path
          squash_q      <= 1'b1;
          outstanding_q <= 1'b0;
        end
      end else if (boot_q) begin
        pend_q <= 1'b1;
      end else begin
        pend_q <= l1i_req_valid && !l1i_req_ready;  // hold until the cache takes it
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (redirect_valid) pend_addr_q <= redirect_pc;
    else if (boot_q) pend_addr_q <= RESET_PC;
    else if (!pend_q) pend_addr_q <= next_pc;  // kept only if the request stalls
    if (req_fire) await_pc_q <= l1i_req_addr;
  end

  a_req_hold: assert property (@(posedge clk_in) disable iff (rst_N_in)
    l1i_req_valid && !l1i_req_ready && !redirect_valid
      |=> l1i_req_valid && $stable(l1i_req_addr))
    else $error("l1i request withdrawn or changed before ready");

endmodule

//--- design/bp_pkg.sv
package bp_pkg;

  // core sizes
  localparam int ADDR_W     = 64;
  localparam int LINE_BYTES = 64;
  localparam int SS_WIDTH   = 4;    // slots per fetch window
  localparam int PHT_K      = 4;    // history bits
  localparam int PHT_N      = 6;    // pc bits, from bit 2 up
  localparam int PHT_SIZE   = 1024;
  localparam int RAS_DEPTH  = 8;
  localparam logic [ADDR_W-1:0] RESET_PC = '0;

  // derived widths
  localparam int LINE_OFF_W = $clog2(LINE_BYTES);   // byte offset inside a line
  localparam int SLOT_IDX_W = $clog2(SS_WIDTH);
  localparam int CNT_W      = 3;                    // window slot count 0..4
  localparam int PHT_IDX_W  = PHT_K + PHT_N;
  localparam int RAS_PTR_W  = $clog2(RAS_DEPTH);
  localparam int RAS_CNT_W  = $clog2(RAS_DEPTH + 1);

  // opcode match fields
  localparam logic [5:0]  OP_B     = 6'b000101;                 // bits 31:26
  localparam logic [5:0]  OP_BL    = 6'b100101;                 // bits 31:26
  localparam logic [7:0]  OP_BCOND = 8'b01010100;               // bits 31:24
  localparam logic [21:0] OP_RET   = 22'b1101011001011111000000; // bits 31:10

  typedef enum logic [2:0] {
    NONE,
    B,
    BL,
    RET,
    BCOND
  } br_kind_e;

  typedef logic [LINE_BYTES-1:0][7:0] line_t;  // byte 0 at the low end

  typedef struct packed {
    br_kind_e          kind;
    logic              predict_taken;
    logic [3:0]        cond;     // b.cond condition field
    logic [ADDR_W-1:0] target;
  } slot_info_t;

  typedef struct packed {
    logic [ADDR_W-1:0]                start_pc;
    logic [CNT_W-1:0]                 count;
    slot_info_t [SS_WIDTH-1:0]        slots;
  } window_t;

  typedef struct packed {
    window_t              win;
    logic [SLOT_IDX_W-1:0] end_idx;    // last slot of the window
    br_kind_e             end_kind;
    logic [ADDR_W-1:0]    end_pc;
    logic [ADDR_W-1:0]    end_target; // static target, zero for ret
  } decode_t;

  typedef struct packed {
    logic [ADDR_W-1:0] pc;
    logic              taken;
  } resolve_t;

  typedef struct packed {
    logic [ADDR_W-1:0]  pc;
    logic signed [18:0] offset;  // in words
  } redirect_t;

  function automatic br_kind_e classify(input logic [31:0] instr);
    br_kind_e kind;
    kind = NONE;
    if (instr[31:26] == OP_B) kind = B;
    else if (instr[31:26] == OP_BL) kind = BL;
    else if (instr[31:10] == OP_RET && instr[4:0] == 5'd0) kind = RET;  // ret with low bits zero
    else if (instr[31:24] == OP_BCOND && !instr[4]) kind = BCOND;
    return kind;
  endfunction

  // byte offset of b / bl
  function automatic logic [ADDR_W-1:0] imm26_off(input logic [31:0] instr);
    return {{(ADDR_W-28){instr[25]}}, instr[25:0], 2'b00};
  endfunction

  // byte offset of b.cond
  function automatic logic [ADDR_W-1:0] imm19_off(input logic [31:0] instr);
    return {{(ADDR_W-21){instr[23]}}, instr[23:5], 2'b00};
  endfunction

endpackage
